// File: ids_pkg.sv
package ids_pkg;

   // Widths that carry a meaning
   typedef logic [5:0]  stream_id_t;
   typedef logic [7:0]  byte_t;
   // Number of keyword characters matched so far (0 to KW_LEN)
   typedef logic [2:0]  dfa_state_t;
   typedef logic [15:0] pkt_count_t;
   typedef logic [7:0]  apb_addr_t;
   typedef logic [31:0] apb_data_t;

   localparam int NUM_RULES   = 2;
   localparam int NUM_STREAMS = 64;
   localparam int KW_LEN      = 4;
   // Bits needed to index one keyword character
   localparam int KW_IDX_W    = $clog2(KW_LEN);

   // One keyword per rule with its first character at index 0
   // Rule 0 is the POP3 USER command and rule 1 is PASS
   localparam byte_t KW_TABLE [NUM_RULES][KW_LEN] = '{
      '{8'h55, 8'h53, 8'h45, 8'h52},
      '{8'h50, 8'h41, 8'h53, 8'h53}
   };

   // APB register map
   // Bit 0 of the control word written as 1 empties the seen-stream table
   localparam apb_addr_t ADDR_CTRL     = 8'h00;
   // Enable bitmap of rule r in a low word at base+8r and a high word at base+8r+4
   localparam apb_addr_t ADDR_EN_BASE  = 8'h10;
   localparam int        EN_RULE_STEP  = 8;
   localparam int        EN_HI_OFFSET  = 4;
   // Packet count of rule r at base+4r is cleared by any write
   localparam apb_addr_t ADDR_CNT_BASE = 8'h30;
   localparam int        CNT_RULE_STEP = 4;

   // Streams covered by one 32-bit enable word
   localparam int EN_WORD_BITS = 32;

endpackage

// File: kw_dfa.sv
`timescale 1ns/1ns

module kw_dfa #(
   parameter int RULE = 0
) (
   input  logic                clk,
   input  logic                rst_n,
   input  ids_pkg::byte_t      char_in,
   input  logic                char_in_vld,
   input  ids_pkg::dfa_state_t state_in,
   input  logic                state_in_vld,
   output ids_pkg::dfa_state_t state_out,
   output logic                accept_out
);

   import ids_pkg::*;

   // Matched length held between bytes
   dfa_state_t cur_state;
   // State this cycle's byte is applied to
   dfa_state_t eff_state;
   dfa_state_t nxt_state;

   // A restored state replaces the held one before the byte is seen
   assign eff_state = state_in_vld ? state_in : cur_state;

   always_comb
   begin
      nxt_state  = eff_state;
      accept_out = 1'b0;
      if (char_in_vld)
      begin
         if (char_in == KW_TABLE[RULE][eff_state[KW_IDX_W-1:0]])
         begin
            // Last character completes the keyword
            if (eff_state == dfa_state_t'(KW_LEN - 1))
            begin
               accept_out = 1'b1;
               nxt_state  = '0;
            end
            else
            begin
               nxt_state = eff_state + dfa_state_t'(1);
            end
         end
         // Mismatch may still start a new attempt
         else if (char_in == KW_TABLE[RULE][0])
         begin
            nxt_state = dfa_state_t'(1);
         end
         else
         begin
            nxt_state = '0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         cur_state <= '0;
      else
         cur_state <= nxt_state;
   end

   // State after this cycle, so an eop cycle saves the final value
   assign state_out = nxt_state;

endmodule

// File: stream_table.sv
`timescale 1ns/1ns

module stream_table (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                sop,
   input  logic                clear_seen,
   input  ids_pkg::stream_id_t stream_id,
   output logic                load_state,
   output logic                new_stream_id,
   output ids_pkg::stream_id_t cur_stream
);

   import ids_pkg::*;

   // One bit per stream, set once a packet of it has been seen
   logic [NUM_STREAMS-1:0] seen;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         seen          <= '0;
         load_state    <= 1'b0;
         new_stream_id <= 1'b0;
         cur_stream    <= '0;
      end
      else
      begin
         // Single-cycle restore request after sop
         load_state <= sop;

         // Emptying the table goes first so a same-cycle sop still registers
         if (clear_seen)
            seen <= '0;

         if (sop)
         begin
            // Held for the whole packet
            cur_stream    <= stream_id;
            new_stream_id <= clear_seen | ~seen[stream_id];
            seen[stream_id] <= 1'b1;
         end
      end
   end

endmodule

// File: stream_rule_ctx.sv
`timescale 1ns/1ns

module stream_rule_ctx #(
   parameter int RULE = 0
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                load_state,
   input  logic                new_stream_id,
   input  logic                eop,
   input  logic                enable,
   input  logic                char_in_vld,
   input  logic                cnt_clear,
   input  ids_pkg::stream_id_t stream_id,
   input  ids_pkg::byte_t      char_in,
   output ids_pkg::pkt_count_t count,
   output logic                fired
);

   import ids_pkg::*;

   // Saved automaton state per stream
   dfa_state_t state_mem [NUM_STREAMS];

   dfa_state_t state_in;
   logic       state_in_vld;
   dfa_state_t state_out;
   logic       accept_out;

   // Set once the keyword is seen in the current packet
   logic       match_flag;

   assign fired = match_flag;

   // Restore one cycle after load_state
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state_in_vld <= 1'b0;
      else
         state_in_vld <= load_state;
   end

   // New streams start from the idle state
   always_ff @(posedge clk)
   begin
      if (load_state)
         state_in <= new_stream_id ? dfa_state_t'(0) : state_mem[stream_id];
   end

   // Disabled packets leave the saved state untouched
   always_ff @(posedge clk)
   begin
      if (eop && enable)
         state_mem[stream_id] <= state_out;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         match_flag <= 1'b0;
         count      <= '0;
      end
      else
      begin
         // Fresh flag for every packet
         if (load_state)
            match_flag <= 1'b0;
         if (accept_out)
            match_flag <= 1'b1;
         // Drop the match when this rule is off for the stream
         if (eop && !enable)
            match_flag <= 1'b0;

         // Clear from APB takes priority over the eop update
         if (cnt_clear)
            count <= '0;
         else if (eop && enable)
            count <= count + pkt_count_t'(match_flag);
      end
   end

   kw_dfa #(
      .RULE (RULE)
   ) u_kw_dfa (
      .clk          (clk),
      .rst_n        (rst_n),
      .char_in      (char_in),
      .char_in_vld  (char_in_vld),
      .state_in     (state_in),
      .state_in_vld (state_in_vld),
      .state_out    (state_out),
      .accept_out   (accept_out)
   );

endmodule

// File: apb_rule_regs.sv
`timescale 1ns/1ns

module apb_rule_regs (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 psel,
   input  logic                 penable,
   input  logic                 pwrite,
   input  ids_pkg::apb_addr_t   paddr,
   input  ids_pkg::apb_data_t   pwdata,
   output ids_pkg::apb_data_t   prdata,
   output logic                 pready,
   output logic                 pslverr,
   input  ids_pkg::stream_id_t  cur_stream,
   input  ids_pkg::pkt_count_t  count0,
   input  ids_pkg::pkt_count_t  count1,
   output logic                 enable0,
   output logic                 enable1,
   output logic                 cnt_clear0,
   output logic                 cnt_clear1,
   output logic                 clear_seen
);

   import ids_pkg::*;

   // Enable bitmap per rule with bit n for stream n
   logic [NUM_STREAMS-1:0] en_map [NUM_RULES];

   pkt_count_t counts [NUM_RULES];

   logic       setup_ph;
   logic       wr_access;
   logic       addr_hit;
   apb_data_t  rd_data;
   // Per-rule decode of the current address
   logic [NUM_RULES-1:0] hit_en_lo;
   logic [NUM_RULES-1:0] hit_en_hi;
   logic [NUM_RULES-1:0] hit_cnt;

   assign counts[0] = count0;
   assign counts[1] = count1;

   // No wait states
   assign pready = 1'b1;

   assign setup_ph  = psel & ~penable;
   assign wr_access = psel & penable & pwrite;

   // Address decode and read mux
   always_comb
   begin
      addr_hit  = (paddr == ADDR_CTRL);
      rd_data   = '0;
      hit_en_lo = '0;
      hit_en_hi = '0;
      hit_cnt   = '0;
      for (int r = 0; r < NUM_RULES; r++)
      begin
         hit_en_lo[r] = (paddr == apb_addr_t'(ADDR_EN_BASE + EN_RULE_STEP * r));
         hit_en_hi[r] = (paddr == apb_addr_t'(ADDR_EN_BASE + EN_RULE_STEP * r
                                              + EN_HI_OFFSET));
         hit_cnt[r]   = (paddr == apb_addr_t'(ADDR_CNT_BASE + CNT_RULE_STEP * r));
         if (hit_en_lo[r])
            rd_data = en_map[r][EN_WORD_BITS-1:0];
         if (hit_en_hi[r])
            rd_data = en_map[r][NUM_STREAMS-1:EN_WORD_BITS];
         if (hit_cnt[r])
            rd_data = apb_data_t'(counts[r]);
      end
      addr_hit = addr_hit | (|hit_en_lo) | (|hit_en_hi) | (|hit_cnt);
   end

   // Read data and error are captured in setup and held through access
   always_ff @(posedge clk)
   begin
      if (setup_ph && !pwrite)
         prdata <= rd_data;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         pslverr <= 1'b0;
      else
         pslverr <= setup_ph & ~addr_hit;
   end

   // Enable words are written in the access phase
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int r = 0; r < NUM_RULES; r++)
            en_map[r] <= '0;
      end
      else if (wr_access)
      begin
         for (int r = 0; r < NUM_RULES; r++)
         begin
            if (hit_en_lo[r])
               en_map[r][EN_WORD_BITS-1:0] <= pwdata;
            if (hit_en_hi[r])
               en_map[r][NUM_STREAMS-1:EN_WORD_BITS] <= pwdata;
         end
      end
   end

   // Clear pulses land on the edge that ends the access phase
   assign cnt_clear0 = wr_access & hit_cnt[0];
   assign cnt_clear1 = wr_access & hit_cnt[1];
   assign clear_seen = wr_access & (paddr == ADDR_CTRL) & pwdata[0];

   // Per-stream enable for the packet in flight
   assign enable0 = en_map[0][cur_stream];
   assign enable1 = en_map[1][cur_stream];

endmodule

// File: ids_top.sv
`timescale 1ns/1ns

module ids_top (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                sop,
   input  logic                eop,
   input  logic                char_in_vld,
   input  ids_pkg::stream_id_t stream_id,
   input  ids_pkg::byte_t      char_in,
   input  logic                psel,
   input  logic                penable,
   input  logic                pwrite,
   input  ids_pkg::apb_addr_t  paddr,
   input  ids_pkg::apb_data_t  pwdata,
   output ids_pkg::apb_data_t  prdata,
   output logic                pready,
   output logic                pslverr,
   output logic                fired0,
   output logic                fired1
);

   import ids_pkg::*;

   // Packet context from the stream table
   logic       load_state;
   logic       new_stream_id;
   stream_id_t cur_stream;

   // Register block to rule engines
   logic       enable0;
   logic       enable1;
   logic       cnt_clear0;
   logic       cnt_clear1;
   logic       clear_seen;
   pkt_count_t count0;
   pkt_count_t count1;

   stream_table u_stream_table (
      .clk           (clk),
      .rst_n         (rst_n),
      .sop           (sop),
      .clear_seen    (clear_seen),
      .stream_id     (stream_id),
      .load_state    (load_state),
      .new_stream_id (new_stream_id),
      .cur_stream    (cur_stream)
   );

   // Rule 0 counts USER
   stream_rule_ctx #(
      .RULE (0)
   ) u_rule0 (
      .clk           (clk),
      .rst_n         (rst_n),
      .load_state    (load_state),
      .new_stream_id (new_stream_id),
      .eop           (eop),
      .enable        (enable0),
      .char_in_vld   (char_in_vld),
      .cnt_clear     (cnt_clear0),
      .stream_id     (cur_stream),
      .char_in       (char_in),
      .count         (count0),
      .fired         (fired0)
   );

   // Rule 1 counts PASS
   stream_rule_ctx #(
      .RULE (1)
   ) u_rule1 (
      .clk           (clk),
      .rst_n         (rst_n),
      .load_state    (load_state),
      .new_stream_id (new_stream_id),
      .eop           (eop),
      .enable        (enable1),
      .char_in_vld   (char_in_vld),
      .cnt_clear     (cnt_clear1),
      .stream_id     (cur_stream),
      .char_in       (char_in),
      .count         (count1),
      .fired         (fired1)
   );

   apb_rule_regs u_regs (
      .clk        (clk),
      .rst_n      (rst_n),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .cur_stream (cur_stream),
      .count0     (count0),
      .count1     (count1),
      .enable0    (enable0),
      .enable1    (enable1),
      .cnt_clear0 (cnt_clear0),
      .cnt_clear1 (cnt_clear1),
      .clear_seen (clear_seen)
   );

endmodule

// File: ids_assert.sv
`timescale 1ns/1ns

module ids_assert (
   input logic clk,
   input logic rst_n,
   input logic psel,
   input logic penable,
   input logic sop,
   input logic eop,
   input logic char_in_vld
);

   // Access phase only ever follows a setup phase of the same transfer
   a_penable_after_psel: assert property (@(posedge clk) disable iff (!rst_n)
      penable |-> psel && $past(psel))
      else $error("penable seen without psel in this and the previous cycle");

   // Setup lasts exactly one cycle
   a_setup_then_access: assert property (@(posedge clk) disable iff (!rst_n)
      psel && !penable |=> penable)
      else $error("APB setup phase not followed by an access phase");

   // Framing cycles carry no byte
   a_no_byte_in_framing: assert property (@(posedge clk) disable iff (!rst_n)
      (sop || eop) |-> !char_in_vld)
      else $error("char_in_vld asserted in a sop or eop cycle");

   a_sop_eop_apart: assert property (@(posedge clk) disable iff (!rst_n)
      !(sop && eop))
      else $error("sop and eop in the same cycle");

   // Idle gap needed between packets
   a_gap_after_eop: assert property (@(posedge clk) disable iff (!rst_n)
      eop |=> !sop)
      else $error("sop in the cycle right after eop");

endmodule

bind ids_top ids_assert u_ids_assert (
   .clk         (clk),
   .rst_n       (rst_n),
   .psel        (psel),
   .penable     (penable),
   .sop         (sop),
   .eop         (eop),
   .char_in_vld (char_in_vld)
);

// File: ids_tb.sv
`timescale 1ns/1ns

module ids_tb;

   import ids_pkg::*;

   localparam int CLK_HALF       = 50;
   localparam int RST_CYCLES     = 8;
   localparam logic [31:0] SEED  = 32'h3585ddfe;
   // Budget of 400 packets at 20 cycles each plus room for APB traffic
   localparam int MAX_PACKETS    = 400;
   localparam int CYCLES_PER_PKT = 20;
   localparam int TIMEOUT_CYCLES = MAX_PACKETS * CYCLES_PER_PKT + 2000;
   localparam int POOL_SIZE      = 8;
   localparam int NUM_BATCHES    = 6;
   localparam int BATCH_PKTS     = 45;
   localparam int MAX_PKT_LEN    = 12;

   logic       clk;
   logic       rst_n;
   logic       sop;
   logic       eop;
   logic       char_in_vld;
   stream_id_t stream_id;
   byte_t      char_in;
   logic       psel;
   logic       penable;
   logic       pwrite;
   apb_addr_t  paddr;
   apb_data_t  pwdata;
   apb_data_t  prdata;
   logic       pready;
   logic       pslverr;
   logic       fired0;
   logic       fired1;

   // Reference model of seen table, enables, saved match length and counts
   logic [NUM_STREAMS-1:0] m_seen;
   logic [NUM_STREAMS-1:0] m_en [NUM_RULES];
   int                     m_state [NUM_STREAMS][NUM_RULES];
   pkt_count_t             m_cnt [NUM_RULES];
   // Keyword seen in the packet being sent
   logic                   m_hit [NUM_RULES];
   // Saved states are unknown until every pool stream has been primed
   logic                   fired_checks_on;

   stream_id_t pool [POOL_SIZE];
   int         cycle_cnt = 0;

   ids_top dut0 (
      .clk         (clk),
      .rst_n       (rst_n),
      .sop         (sop),
      .eop         (eop),
      .char_in_vld (char_in_vld),
      .stream_id   (stream_id),
      .char_in     (char_in),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .fired0      (fired0),
      .fired1      (fired1)
   );

   initial clk = 1'b0;
   always #CLK_HALF clk = ~clk;

   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TEST FAILED");
         $fatal(1, "Simulation stopped by timeout");
      end
   end

   task automatic check_count(input string name, input pkt_count_t got, input pkt_count_t exp);
      if (got !== exp)
      begin
         $display("FAIL at %0t: %s is %0d, expected %0d", $time, name, got, exp);
         $display("TEST FAILED");
         $fatal(1, "Stopping at first mismatch");
      end
   endtask

   task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
      if (got !== exp)
      begin
         $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp);
         $display("TEST FAILED");
         $fatal(1, "Stopping at first mismatch");
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("FAIL at %0t: %s is %b, expected %b", $time, name, got, exp);
         $display("TEST FAILED");
         $fatal(1, "Stopping at first mismatch");
      end
   endtask

   // Character i of the keyword of rule r, first character leftmost
   function automatic byte_t kw_char(input int r, input int i);
      logic [8*KW_LEN-1:0] word;
      word = (r == 0) ? "USER" : "PASS";
      return word[8*(KW_LEN-1-i) +: 8];
   endfunction

   // Matched length after one byte; KW_LEN means the keyword just completed
   function automatic int next_match_len(input int r, input int len, input byte_t b);
      if (b == kw_char(r, len))
         return len + 1;
      else if (b == kw_char(r, 0))
         return 1;
      else
         return 0;
   endfunction

   function automatic apb_addr_t en_addr(input int r, input int hi);
      return apb_addr_t'(int'(ADDR_EN_BASE) + 8 * r + 4 * hi);
   endfunction

   function automatic apb_addr_t cnt_addr(input int r);
      return apb_addr_t'(int'(ADDR_CNT_BASE) + 4 * r);
   endfunction

   // Mostly keyword letters so that matches and near misses are common
   function automatic byte_t random_byte();
      logic [8*7-1:0] alpha;
      int             k;
      alpha = "USERPAS";
      k = int'($urandom_range(7));
      if (k == 7)
         return byte_t'($urandom());
      return alpha[8*(6-k) +: 8];
   endfunction

   task automatic predict_packet(input stream_id_t id, input byte_t data[$]);
      logic is_new;
      int   len;
      is_new = ~m_seen[id];
      m_seen[id] = 1'b1;
      for (int r = 0; r < NUM_RULES; r++)
      begin
         len = is_new ? 0 : m_state[id][r];
         m_hit[r] = 1'b0;
         foreach (data[i])
         begin
            len = next_match_len(r, len, data[i]);
            if (len == KW_LEN)
            begin
               m_hit[r] = 1'b1;
               len = 0;
            end
         end
         // A disabled rule neither counts nor saves its state
         if (m_en[r][id])
         begin
            m_state[id][r] = len;
            if (m_hit[r])
               m_cnt[r] = m_cnt[r] + pkt_count_t'(1);
         end
      end
   endtask

   // sop, one load cycle, the bytes, eop, then one idle cycle
   task automatic send_packet(input stream_id_t id, input byte_t data[$]);
      predict_packet(id, data);
      @(posedge clk);
      sop       <= 1'b1;
      stream_id <= id;
      @(posedge clk);
      sop <= 1'b0;
      foreach (data[i])
      begin
         @(posedge clk);
         char_in_vld <= 1'b1;
         char_in     <= data[i];
      end
      @(posedge clk);
      char_in_vld <= 1'b0;
      eop         <= 1'b1;
      // Match flags settle before mid-cycle of eop
      @(negedge clk);
      if (fired_checks_on)
      begin
         check_flag("fired0", fired0, m_hit[0]);
         check_flag("fired1", fired1, m_hit[1]);
      end
      @(posedge clk);
      eop <= 1'b0;
   endtask

   task automatic send_text(input stream_id_t id, input string s);
      byte_t data[$];
      for (int i = 0; i < s.len(); i++)
         data.push_back(s[i]);
      send_packet(id, data);
   endtask

   task automatic send_random_packet();
      byte_t      data[$];
      int         n;
      stream_id_t id;
      id = pool[$urandom_range(POOL_SIZE - 1)];
      n  = int'($urandom_range(MAX_PKT_LEN));
      for (int i = 0; i < n; i++)
         data.push_back(random_byte());
      send_packet(id, data);
   endtask

   task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;
      // Error flag and ready are valid during the access phase
      @(negedge clk);
      err = pslverr;
      check_flag("pready", pready, 1'b1);
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      data = prdata;
      err  = pslverr;
      check_flag("pready", pready, 1'b1);
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic set_enables(input int r, input logic [NUM_STREAMS-1:0] map);
      logic err;
      apb_write(en_addr(r, 0), map[31:0], err);
      check_flag("pslverr", err, 1'b0);
      apb_write(en_addr(r, 1), map[63:32], err);
      check_flag("pslverr", err, 1'b0);
      m_en[r] = map;
   endtask

   task automatic check_enables();
      apb_data_t rdata;
      logic      err;
      for (int r = 0; r < NUM_RULES; r++)
      begin
         apb_read(en_addr(r, 0), rdata, err);
         check_flag("pslverr", err, 1'b0);
         check_data($sformatf("enable%0d_lo", r), rdata, m_en[r][31:0]);
         apb_read(en_addr(r, 1), rdata, err);
         check_flag("pslverr", err, 1'b0);
         check_data($sformatf("enable%0d_hi", r), rdata, m_en[r][63:32]);
      end
   endtask

   task automatic read_count(input int r, output pkt_count_t c);
      apb_data_t rdata;
      logic      err;
      apb_read(cnt_addr(r), rdata, err);
      check_flag("pslverr", err, 1'b0);
      // Upper half of a count word reads as zero
      check_data("prdata_hi", rdata & 32'hffff_0000, '0);
      c = pkt_count_t'(rdata);
   endtask

   task automatic check_counts();
      pkt_count_t c;
      for (int r = 0; r < NUM_RULES; r++)
      begin
         read_count(r, c);
         check_count($sformatf("count%0d", r), c, m_cnt[r]);
      end
   endtask

   task automatic clear_seen_table();
      logic err;
      apb_write(ADDR_CTRL, 32'h1, err);
      check_flag("pslverr", err, 1'b0);
      m_seen = '0;
   endtask

   initial
   begin
      byte_t                  empty[$];
      logic [NUM_STREAMS-1:0] map;
      pkt_count_t             base0;
      pkt_count_t             base1;
      pkt_count_t             c;
      apb_data_t              rdata;
      logic                   err;
      void'($urandom(SEED));
      rst_n       = 1'b0;
      sop         = 1'b0;
      eop         = 1'b0;
      char_in_vld = 1'b0;
      stream_id   = '0;
      char_in     = '0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      m_seen          = '0;
      fired_checks_on = 1'b0;
      for (int r = 0; r < NUM_RULES; r++)
      begin
         m_en[r]  = '0;
         m_cnt[r] = '0;
         for (int s = 0; s < NUM_STREAMS; s++)
            m_state[s][r] = 0;
      end
      // Both enable words of each rule and both halves of the id space
      pool = '{6'd0, 6'd5, 6'd12, 6'd31, 6'd32, 6'd40, 6'd57, 6'd63};
      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;

      // Reset values, then traffic with every rule off
      check_enables();
      check_counts();
      repeat (40) send_random_packet();
      check_counts();

      // Fresh seen table and one empty packet per stream set all saved states to 0
      clear_seen_table();
      set_enables(0, '1);
      set_enables(1, '1);
      foreach (pool[i])
         send_packet(pool[i], empty);
      fired_checks_on = 1'b1;
      check_counts();

      // Random enable bitmaps per batch
      for (int b = 0; b < NUM_BATCHES; b++)
      begin
         for (int r = 0; r < NUM_RULES; r++)
         begin
            map = {$urandom(), $urandom()};
            set_enables(r, map);
         end
         check_enables();
         repeat (BATCH_PKTS) send_random_packet();
         check_counts();
      end

      // Keyword split across two packets of one stream
      set_enables(0, '1);
      set_enables(1, '1);
      base0 = m_cnt[0];
      base1 = m_cnt[1];
      send_text(pool[1], "xxUS");
      send_text(pool[1], "ERxx");
      send_text(pool[3], "xPA");
      send_text(pool[3], "SS");
      read_count(0, c);
      check_count("count0", c, base0 + pkt_count_t'(1));
      read_count(1, c);
      check_count("count1", c, base1 + pkt_count_t'(1));

      // After a seen-table clear the same split starts from zero
      send_text(pool[1], "xxUS");
      clear_seen_table();
      send_text(pool[1], "ERxx");
      read_count(0, c);
      check_count("count0", c, base0 + pkt_count_t'(1));
      check_counts();

      // Disabled packet leaves the saved state alone
      base0 = m_cnt[0];
      send_text(pool[2], "xUS");
      map = m_en[0];
      map[pool[2]] = 1'b0;
      set_enables(0, map);
      send_text(pool[2], "xxxx");
      set_enables(0, '1);
      send_text(pool[2], "ERx");
      read_count(0, c);
      check_count("count0", c, base0 + pkt_count_t'(1));
      check_counts();

      // A count write clears only that count
      base1 = m_cnt[1];
      apb_write(cnt_addr(0), $urandom(), err);
      check_flag("pslverr", err, 1'b0);
      m_cnt[0] = '0;
      read_count(1, c);
      check_count("count1", c, base1);
      check_counts();
      apb_write(cnt_addr(1), $urandom(), err);
      check_flag("pslverr", err, 1'b0);
      m_cnt[1] = '0;
      check_counts();

      // Unmapped addresses answer with an error, mapped ones do not
      apb_read(8'h08, rdata, err);
      check_flag("pslverr", err, 1'b1);
      apb_write(8'h20, $urandom(), err);
      check_flag("pslverr", err, 1'b1);
      apb_read(8'hfc, rdata, err);
      check_flag("pslverr", err, 1'b1);
      apb_read(ADDR_CTRL, rdata, err);
      check_flag("pslverr", err, 1'b0);
      check_enables();

      $display("TEST OK");
      $finish;
   end

endmodule

// File: filelist.f
ids_pkg.sv
kw_dfa.sv
stream_table.sv
stream_rule_ctx.sv
apb_rule_regs.sv
ids_top.sv
ids_assert.sv
ids_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module ids_tb -f filelist.f -o ids_sim
./obj_dir/ids_sim 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
   echo "Simulation reported a failure"
   exit 1
fi
if ! grep -q "TEST OK" sim.log; then
   echo "Simulation ended without a pass line"
   exit 1
fi
